//--- bench/cpu_tb.sv
// testbench top: clock, reset, LFSR program, ISA reference model, event checks
`timescale 1ns/1ps

module cpu_tb;

	localparam int num_retire = 400;
	localparam int mem_words  = 2048;
	localparam int max_cycles = 400000;

	typedef struct packed {
		logic [15:0] n;
		logic [3:0]  tag;
	} fill_event_t;

	typedef struct packed {
		logic [15:0] n;
		logic        write;
		logic [10:0] addr;
		logic [15:0] wdata;
	} data_event_t;

	logic               clk = 1'b0;
	logic               rst_n;
	cpu_pkg::fill_req_t fill_req;
	cpu_pkg::fill_rsp_t fill_rsp;
	cpu_pkg::data_req_t data_req;
	cpu_pkg::data_rsp_t data_rsp;
	logic               io_stall;

	logic [15:0]        lfsr;
	logic [15:0]        ref_imem [mem_words];
	logic [15:0]        ref_dmem [mem_words];
	logic [15:0]        ref_regs [16];
	fill_event_t        fill_exp [$];
	data_event_t        data_exp [$];

	always #4 clk = ~clk;

	cpu_top UUT (
		.clk      (clk),
		.rst_n    (rst_n),
		.fill_req (fill_req),
		.fill_rsp (fill_rsp),
		.data_req (data_req),
		.data_rsp (data_rsp),
		.io_stall (io_stall)
	);

	mem_model u_mem (
		.clk      (clk),
		.fill_req (fill_req),
		.fill_rsp (fill_rsp),
		.data_req (data_req),
		.data_rsp (data_rsp)
	);

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
			stop_run($sformatf("mismatch %s expected %0h actual %0h", name, expected, actual));
	endtask

	// ----------------------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------------------
	// x^16 + x^14 + x^13 + x^11 + 1, one step per bit
	function automatic logic [15:0] take_bits(input int count);
		logic [15:0] val;
		val = '0;
		for (int i = 0; i < count; i++) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			val = {val[14:0], lfsr[0]};
		end
		return val;
	endfunction

	// weighted toward stores and mult
	function automatic logic [15:0] make_instr();
		logic [3:0]  pick;
		logic [12:0] body;
		logic [2:0]  op;
		pick = 4'(take_bits(4));
		body = 13'(take_bits(13));
		if (pick < 3)
			op = cpu_pkg::op_arith;
		else if (pick < 7)
			op = cpu_pkg::op_slt_mult;
		else if (pick < 11)
			op = cpu_pkg::op_store;
		else if (pick < 13)
			op = cpu_pkg::op_load;
		else if (pick == 13)
			op = cpu_pkg::op_jump;
		else
			op = cpu_pkg::op_beq;
		if (pick == 5 || pick == 6)
			body[0] = 1'b0;
		return {op, body};
	endfunction

	task automatic load_memories();
		logic [15:0] w;
		for (int i = 0; i < mem_words; i++) begin
			w = make_instr();
			ref_imem[i] = w;
			u_mem.imem[i] = w;
		end
		for (int i = 0; i < mem_words; i++) begin
			w = take_bits(16);
			ref_dmem[i] = w;
			u_mem.dmem[i] = w;
		end
		for (int i = 0; i < 256; i++)
			u_mem.delay_tab[i] = 2'(take_bits(2));
		for (int i = 0; i < 16; i++)
			ref_regs[i] = '0;
	endtask

	// ----------------------------------------------------------------------
	// ISA reference model, predicts fills and data requests
	// ----------------------------------------------------------------------
	task automatic run_model();
		int          n;
		logic [15:0] pc;
		logic [15:0] ins;
		logic [10:0] idx;
		logic [3:0]  line_tag;
		logic        line_ok;
		logic [2:0]  op;
		logic [3:0]  rs;
		logic [3:0]  rt;
		logic [3:0]  rd;
		logic [15:0] imm;
		logic [15:0] a;
		logic [15:0] b;
		logic [31:0] prod;
		logic [15:0] ea;
		logic [10:0] addr;
		pc = 16'h1000;
		line_ok = 1'b0;
		line_tag = '0;
		for (n = 0; n < num_retire; n++) begin
			idx = pc[11:1];
			ins = ref_imem[idx];
			if (!line_ok || idx[10:7] != line_tag) begin
				fill_exp.push_back('{n: 16'(n), tag: idx[10:7]});
				line_ok = 1'b1;
				line_tag = idx[10:7];
			end
			op = ins[15:13];
			rs = ins[12:9];
			rt = ins[8:5];
			rd = ins[4:1];
			imm = {{11{ins[4]}}, ins[4:0]};
			a = ref_regs[rs];
			b = ref_regs[rt];
			// data byte address is based at 0x1000
			ea = (a + imm) * 2 + 16'h1000;
			addr = ea[11:1];
			case (op)
				cpu_pkg::op_arith: begin
					ref_regs[rd] = ins[0] ? a + b : a - b;
					pc = pc + 16'd2;
				end
				cpu_pkg::op_slt_mult: begin
					if (ins[0]) begin
						ref_regs[rd] = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
					end else begin
						prod = $signed(a) * $signed(b);
						ref_regs[rd] = prod[15:0];
					end
					pc = pc + 16'd2;
				end
				cpu_pkg::op_store: begin
					data_exp.push_back('{n: 16'(n), write: 1'b1, addr: addr, wdata: b});
					ref_dmem[addr] = b;
					pc = pc + 16'd2;
				end
				cpu_pkg::op_load: begin
					data_exp.push_back('{n: 16'(n), write: 1'b0, addr: addr, wdata: '0});
					ref_regs[rt] = ref_dmem[addr];
					pc = pc + 16'd2;
				end
				cpu_pkg::op_jump:
					pc = {3'b000, ins[12:0]};
				cpu_pkg::op_beq:
					pc = (a == b) ? pc + 16'd2 + (imm << 1) : pc + 16'd2;
				default:
					stop_run("program holds an opcode the model does not execute");
			endcase
		end
	endtask

	// ----------------------------------------------------------------------
	// run and compare
	// ----------------------------------------------------------------------
	initial begin : main
		int          cycles;
		int          retired;
		int          fill_seen;
		int          data_seen;
		logic        was_low;
		fill_event_t fe;
		data_event_t de;
		rst_n = 1'b0;
		lfsr = 16'd17731;
		load_memories();
		run_model();
		for (int i = 0; i < 8; i++) begin
			@(posedge clk);
			#1;
			check_value("stall in reset", 1, io_stall);
			check_value("fill valid in reset", 0, fill_req.valid);
			check_value("data valid in reset", 0, data_req.valid);
		end
		rst_n = 1'b1;
		cycles = 0;
		retired = 0;
		fill_seen = 0;
		data_seen = 0;
		was_low = 1'b0;
		while (retired < num_retire) begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > max_cycles)
				stop_run("timeout while waiting for instructions to retire");
			if (fill_req.valid) begin
				if (fill_seen >= fill_exp.size())
					stop_run("fill request that the model does not predict");
				fe = fill_exp[fill_seen];
				check_value("fill tag", fe.tag, fill_req.tag);
				check_value("fill position", fe.n, retired);
				fill_seen++;
			end
			if (data_req.valid) begin
				if (fill_seen == 0)
					stop_run("data request came before the first fill request");
				if (data_seen >= data_exp.size())
					stop_run("data request that the model does not predict");
				de = data_exp[data_seen];
				check_value("data position", de.n, retired);
				check_value("data write", de.write, data_req.write);
				check_value("data address", de.addr, data_req.addr);
				if (de.write)
					check_value("store data", de.wdata, data_req.wdata);
				data_seen++;
			end
			// one low cycle per retired instruction
			if (!io_stall) begin
				if (was_low)
					stop_run("io_stall stayed low for more than one cycle");
				retired++;
			end
			was_low = !io_stall;
		end
		@(posedge clk);
		#1;
		check_value("stall after last retire", 1, io_stall);
		check_value("fill count", fill_exp.size(), fill_seen);
		check_value("data count", data_exp.size(), data_seen);
		$display("%0d retired, %0d fills, %0d data requests", retired, fill_seen, data_seen);
		$display("test passed");
		$finish;
	end

endmodule

//--- bench/mem_model.sv
// memory responder: instruction line bursts with random gaps, data reads and writes
`timescale 1ns/1ps

module mem_model (
	input  logic               clk,
	input  cpu_pkg::fill_req_t fill_req,
	output cpu_pkg::fill_rsp_t fill_rsp,
	input  cpu_pkg::data_req_t data_req,
	output cpu_pkg::data_rsp_t data_rsp
);

	logic [cpu_pkg::word_w-1:0] imem [2048];
	logic [cpu_pkg::word_w-1:0] dmem [2048];
	// gap and latency values, loaded by the testbench
	logic [1:0]                 delay_tab [256];
	logic [7:0]                 delay_ptr = '0;

	function automatic logic [1:0] next_delay();
		logic [1:0] d;
		d = delay_tab[delay_ptr];
		delay_ptr = delay_ptr + 8'd1;
		return d;
	endfunction

	// ----------------------------------------------------------------------
	// line refill, beats in word order
	// ----------------------------------------------------------------------
	initial begin : fill_side
		logic [cpu_pkg::addr_w-1:0] base;
		logic [1:0]                 gap;
		fill_rsp = '0;
		forever begin
			@(posedge clk);
			#1;
			if (fill_req.valid) begin
				base = {fill_req.tag, 7'd0};
				for (int beat = 0; beat < cpu_pkg::line_words; beat++) begin
					gap = next_delay();
					repeat (gap) begin
						@(posedge clk);
						#1;
					end
					fill_rsp = '{
						valid: 1'b1,
						last:  (beat == cpu_pkg::line_words - 1),
						data:  imem[base + beat]
					};
					@(posedge clk);
					#1;
					fill_rsp = '0;
				end
			end
		end
	end

	// ----------------------------------------------------------------------
	// single-word data port
	// ----------------------------------------------------------------------
	initial begin : data_side
		cpu_pkg::data_req_t req;
		logic [2:0]         wait_cycles;
		data_rsp = '0;
		forever begin
			@(posedge clk);
			#1;
			if (data_req.valid) begin
				req = data_req;
				// answer comes one to four cycles after the request
				wait_cycles = 3'd1 + next_delay();
				repeat (wait_cycles) begin
					@(posedge clk);
					#1;
				end
				if (req.write) begin
					dmem[req.addr] = req.wdata;
					data_rsp = '{valid: 1'b1, rdata: '0};
				end else begin
					data_rsp = '{valid: 1'b1, rdata: dmem[req.addr]};
				end
				@(posedge clk);
				#1;
				data_rsp = '0;
			end
		end
	end

endmodule

//--- project.f
source/cpu_pkg.sv
source/inst_cache.sv
source/reg_file.sv
source/exec_unit.sv
source/core_ctrl.sv
source/cpu_top.sv
bench/mem_model.sv
bench/cpu_tb.sv

//--- source/core_ctrl.sv
// instruction sequencer: state machine, pc, data strobes, register writes, io_stall
`timescale 1ns/1ps

module core_ctrl (
	input  logic                              clk,
	input  logic                              rst_n,
	output logic                              fetch,
	output logic [cpu_pkg::addr_w-1:0]        pc_index,
	input  logic                              inst_valid,
	input  cpu_pkg::instr_t                   inst,
	input  logic [cpu_pkg::word_w-1:0]        result,
	input  logic [cpu_pkg::word_w-1:0]        product,
	input  logic                              equal,
	input  logic [cpu_pkg::addr_w-1:0]        data_addr,
	input  logic [cpu_pkg::word_w-1:0]        rt_val,
	output logic                              latch,
	output cpu_pkg::alu_sel_e                 sel,
	output logic signed [cpu_pkg::imm_w-1:0]  imm,
	output logic [cpu_pkg::reg_num_w-1:0]     rs_num,
	output logic [cpu_pkg::reg_num_w-1:0]     rt_num,
	output cpu_pkg::reg_write_t               wr,
	output cpu_pkg::data_req_t                data_req,
	input  cpu_pkg::data_rsp_t                data_rsp,
	output logic                              io_stall
);

	cpu_pkg::core_state_e state;
	cpu_pkg::core_state_e state_nx;

	logic [cpu_pkg::word_w-1:0]        pc;
	logic [cpu_pkg::word_w-1:0]        pc_nx;
	logic signed [cpu_pkg::word_w-1:0] imm_ext;
	cpu_pkg::instr_t                   inst_q;
	cpu_pkg::instr_t                   cur;
	logic                              is_mult;
	logic                              is_load;
	logic                              entering_fetch;
	logic                              req_pulse;

	// new word is on the cache output before it lands in inst_q
	assign cur     = inst_valid ? inst : inst_q;
	assign is_mult = (inst_q.opcode == cpu_pkg::op_slt_mult) && !inst_q.funct;
	assign is_load = inst_q.opcode[0];
	assign imm     = cpu_pkg::get_imm(inst_q);
	assign imm_ext = {{(cpu_pkg::word_w - cpu_pkg::imm_w){imm[cpu_pkg::imm_w-1]}}, imm};

	// ----------------------------------------------------------------------
	// state machine
	// ----------------------------------------------------------------------
	always_comb begin
		state_nx = state;
		case (state)
			cpu_pkg::st_init:
				state_nx = cpu_pkg::st_fetch;
			cpu_pkg::st_fetch: begin
				// decoded by bits so 11x lands in data like 01x
				if (inst_valid) begin
					if (inst.opcode[1])
						state_nx = cpu_pkg::st_data;
					else if (inst.opcode[2])
						state_nx = cpu_pkg::st_branch;
					else
						state_nx = cpu_pkg::st_execute;
				end
			end
			cpu_pkg::st_execute: begin
				if (is_mult)
					state_nx = cpu_pkg::st_mult;
				else
					state_nx = cpu_pkg::st_fetch;
			end
			cpu_pkg::st_data: begin
				if (data_rsp.valid)
					state_nx = cpu_pkg::st_fetch;
			end
			default:
				state_nx = cpu_pkg::st_fetch;
		endcase
	end

	assign entering_fetch = (state != cpu_pkg::st_fetch) && (state_nx == cpu_pkg::st_fetch);

	// ----------------------------------------------------------------------
	// program counter
	// ----------------------------------------------------------------------
	always_comb begin
		pc_nx = pc;
		if (state == cpu_pkg::st_branch) begin
			if ((inst_q.opcode == cpu_pkg::op_beq) && equal)
				pc_nx = pc + 16'd2 + (imm_ext <<< 1);
			else if (inst_q.opcode == cpu_pkg::op_jump)
				pc_nx = cpu_pkg::word_w'(cpu_pkg::get_target(inst_q));
			else
				pc_nx = pc + 16'd2;
		end else if (entering_fetch && (state != cpu_pkg::st_init)) begin
			pc_nx = pc + 16'd2;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= cpu_pkg::st_init;
			pc        <= cpu_pkg::pc_reset;
			inst_q    <= '0;
			fetch     <= 1'b0;
			io_stall  <= 1'b1;
			req_pulse <= 1'b0;
		end else begin
			state     <= state_nx;
			pc        <= pc_nx;
			fetch     <= entering_fetch;
			// no retire pulse on the way out of init
			io_stall  <= !(entering_fetch && (state != cpu_pkg::st_init));
			req_pulse <= (state != cpu_pkg::st_data) && (state_nx == cpu_pkg::st_data);
			if (inst_valid)
				inst_q <= inst;
		end
	end

	assign pc_index = pc[cpu_pkg::addr_w:1];

	// ----------------------------------------------------------------------
	// operand select and register write
	// ----------------------------------------------------------------------
	assign latch  = inst_valid && (state == cpu_pkg::st_fetch);
	assign rs_num = cur.rs;
	assign rt_num = cur.rt;

	always_comb begin
		case (inst_q.opcode)
			cpu_pkg::op_arith:    sel = inst_q.funct ? cpu_pkg::alu_add : cpu_pkg::alu_sub;
			cpu_pkg::op_slt_mult: sel = cpu_pkg::alu_slt;
			default:              sel = cpu_pkg::alu_add;
		endcase
	end

	always_comb begin
		wr = '0;
		case (state)
			cpu_pkg::st_execute: begin
				wr.en   = !is_mult;
				wr.num  = inst_q.rd;
				wr.data = result;
			end
			cpu_pkg::st_mult: begin
				wr.en   = 1'b1;
				wr.num  = inst_q.rd;
				wr.data = product;
			end
			cpu_pkg::st_data: begin
				// load data goes to rt
				wr.en   = data_rsp.valid && is_load;
				wr.num  = inst_q.rt;
				wr.data = data_rsp.rdata;
			end
			default: ;
		endcase
	end

	// address from the latched rs operand and store data from the rt read port
	assign data_req = '{
		valid: req_pulse,
		write: !is_load,
		addr:  data_addr,
		wdata: rt_val
	};

	a_rsp_in_data: assert property (@(posedge clk) disable iff (!rst_n)
		data_rsp.valid |-> (state == cpu_pkg::st_data) && !data_req.valid);

endmodule

//--- source/cpu_pkg.sv
// widths, opcode and state enums, instruction and port structs, field helpers
package cpu_pkg;

	localparam int word_w     = 16;
	localparam int addr_w     = 11;
	localparam int tag_w      = 4;
	localparam int line_words = 128;
	localparam int line_off_w = 7;
	localparam int reg_count  = 16;
	localparam int reg_num_w  = 4;
	localparam int imm_w      = 5;
	localparam int target_w   = 13;

	// byte address of the first instruction
	localparam logic [word_w-1:0] pc_reset = 16'h1000;

	typedef enum logic [2:0] {
		op_arith    = 3'b000,
		op_slt_mult = 3'b001,
		op_store    = 3'b010,
		op_load     = 3'b011,
		op_jump     = 3'b100,
		op_beq      = 3'b101
	} opcode_e;

	typedef enum logic [2:0] {
		st_init,
		st_fetch,
		st_execute,
		st_mult,
		st_data,
		st_branch
	} core_state_e;

	typedef enum logic [1:0] {
		cs_idle,
		cs_hit,
		cs_fill,
		cs_deliver
	} cache_state_e;

	typedef enum logic [1:0] {
		alu_add,
		alu_sub,
		alu_slt
	} alu_sel_e;

	// ----------------------------------------------------------------------
	// instruction word and port bundles
	// ----------------------------------------------------------------------
	typedef struct packed {
		opcode_e              opcode;
		logic [reg_num_w-1:0] rs;
		logic [reg_num_w-1:0] rt;
		logic [reg_num_w-1:0] rd;
		logic                 funct;
	} instr_t;

	typedef struct packed {
		logic             valid;
		logic [tag_w-1:0] tag;
	} fill_req_t;

	typedef struct packed {
		logic              valid;
		logic              last;
		logic [word_w-1:0] data;
	} fill_rsp_t;

	typedef struct packed {
		logic              valid;
		logic              write;
		logic [addr_w-1:0] addr;
		logic [word_w-1:0] wdata;
	} data_req_t;

	typedef struct packed {
		logic              valid;
		logic [word_w-1:0] rdata;
	} data_rsp_t;

	typedef struct packed {
		logic                 en;
		logic [reg_num_w-1:0] num;
		logic [word_w-1:0]    data;
	} reg_write_t;

	// immediate sits on rd and funct
	function automatic logic signed [imm_w-1:0] get_imm(instr_t i);
		return {i.rd, i.funct};
	endfunction

	// jump target is everything below the opcode
	function automatic logic [target_w-1:0] get_target(instr_t i);
		return {i.rs, i.rt, i.rd, i.funct};
	endfunction

endpackage

//--- source/cpu_top.sv
// processor top: instruction cache, sequencer, register block and execute unit
`timescale 1ns/1ps

module cpu_top (
	input  logic               clk,
	input  logic               rst_n,
	output cpu_pkg::fill_req_t fill_req,
	input  cpu_pkg::fill_rsp_t fill_rsp,
	output cpu_pkg::data_req_t data_req,
	input  cpu_pkg::data_rsp_t data_rsp,
	output logic               io_stall
);

	logic                              fetch;
	logic [cpu_pkg::addr_w-1:0]        pc_index;
	logic                              inst_valid;
	cpu_pkg::instr_t                   inst;
	logic [cpu_pkg::word_w-1:0]        result;
	logic [cpu_pkg::word_w-1:0]        product;
	logic                              equal;
	logic [cpu_pkg::addr_w-1:0]        data_addr;
	logic [cpu_pkg::word_w-1:0]        rs_val;
	logic [cpu_pkg::word_w-1:0]        rt_val;
	logic                              latch;
	cpu_pkg::alu_sel_e                 sel;
	logic signed [cpu_pkg::imm_w-1:0]  imm;
	logic [cpu_pkg::reg_num_w-1:0]     rs_num;
	logic [cpu_pkg::reg_num_w-1:0]     rt_num;
	cpu_pkg::reg_write_t               wr;

	// ----------------------------------------------------------------------
	// instruction side
	// ----------------------------------------------------------------------
	inst_cache u_icache (
		.clk        (clk),
		.rst_n      (rst_n),
		.fetch      (fetch),
		.pc_index   (pc_index),
		.inst_valid (inst_valid),
		.inst       (inst),
		.fill_req   (fill_req),
		.fill_rsp   (fill_rsp)
	);

	core_ctrl u_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.fetch      (fetch),
		.pc_index   (pc_index),
		.inst_valid (inst_valid),
		.inst       (inst),
		.result     (result),
		.product    (product),
		.equal      (equal),
		.data_addr  (data_addr),
		.rt_val     (rt_val),
		.latch      (latch),
		.sel        (sel),
		.imm        (imm),
		.rs_num     (rs_num),
		.rt_num     (rt_num),
		.wr         (wr),
		.data_req   (data_req),
		.data_rsp   (data_rsp),
		.io_stall   (io_stall)
	);

	// ----------------------------------------------------------------------
	// datapath
	// ----------------------------------------------------------------------
	reg_file u_regs (
		.clk    (clk),
		.rst_n  (rst_n),
		.rs_num (rs_num),
		.rt_num (rt_num),
		.rs_val (rs_val),
		.rt_val (rt_val),
		.wr     (wr)
	);

	exec_unit u_exec (
		.clk       (clk),
		.rst_n     (rst_n),
		.latch     (latch),
		.rs_val    (rs_val),
		.rt_val    (rt_val),
		.imm       (imm),
		.sel       (sel),
		.result    (result),
		.product   (product),
		.equal     (equal),
		.data_addr (data_addr)
	);

endmodule

//--- source/exec_unit.sv
// operand latches, add/sub/slt, two-stage multiplier, equality and data address
`timescale 1ns/1ps

module exec_unit (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             latch,
	input  logic [cpu_pkg::word_w-1:0]       rs_val,
	input  logic [cpu_pkg::word_w-1:0]       rt_val,
	input  logic signed [cpu_pkg::imm_w-1:0] imm,
	input  cpu_pkg::alu_sel_e                sel,
	output logic [cpu_pkg::word_w-1:0]       result,
	output logic [cpu_pkg::word_w-1:0]       product,
	output logic                             equal,
	output logic [cpu_pkg::addr_w-1:0]       data_addr
);

	logic signed [cpu_pkg::word_w-1:0] op_a;
	logic signed [cpu_pkg::word_w-1:0] op_b;
	logic signed [cpu_pkg::word_w-1:0] imm_ext;
	logic signed [cpu_pkg::word_w-1:0] ea_word;
	logic [cpu_pkg::word_w-1:0]        ea_byte;
	logic [cpu_pkg::word_w-1:0]        pp_ll;
	logic [7:0]                        pp_cross;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			op_a <= '0;
			op_b <= '0;
		end else if (latch) begin
			op_a <= rs_val;
			op_b <= rt_val;
		end
	end

	// ----------------------------------------------------------------------
	// multiplier
	// ----------------------------------------------------------------------
	// low half of a two's complement product does not depend on sign,
	// so only the lo*lo term and the low byte of the cross terms matter
	always_ff @(posedge clk) begin
		pp_ll    <= op_a[7:0] * op_b[7:0];
		pp_cross <= op_a[15:8] * op_b[7:0] + op_a[7:0] * op_b[15:8];
	end

	assign product = pp_ll + {pp_cross, 8'h00};

	// ----------------------------------------------------------------------
	// arithmetic and compare
	// ----------------------------------------------------------------------
	always_comb begin
		case (sel)
			cpu_pkg::alu_add: result = op_a + op_b;
			cpu_pkg::alu_sub: result = op_a - op_b;
			cpu_pkg::alu_slt: result = {15'd0, op_a < op_b};
			default:          result = op_a + op_b;
		endcase
	end

	assign equal = (op_a == op_b);

	// word index of rs + imm inside the 0x1000 byte window
	assign imm_ext   = {{(cpu_pkg::word_w - cpu_pkg::imm_w){imm[cpu_pkg::imm_w-1]}}, imm};
	assign ea_word   = op_a + imm_ext;
	assign ea_byte   = (ea_word << 1) + cpu_pkg::pc_reset;
	assign data_addr = ea_byte[cpu_pkg::addr_w:1];

endmodule

//--- source/inst_cache.sv
// one-line instruction cache: tag check, burst refill, requested word capture
`timescale 1ns/1ps

module inst_cache (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       fetch,
	input  logic [cpu_pkg::addr_w-1:0] pc_index,
	output logic                       inst_valid,
	output cpu_pkg::instr_t            inst,
	output cpu_pkg::fill_req_t         fill_req,
	input  cpu_pkg::fill_rsp_t         fill_rsp
);

	cpu_pkg::cache_state_e state;
	cpu_pkg::cache_state_e state_nx;

	logic [cpu_pkg::word_w-1:0]     line_mem [cpu_pkg::line_words];
	logic                           line_valid;
	logic [cpu_pkg::tag_w-1:0]      line_tag;
	logic [cpu_pkg::addr_w-1:0]     req_index;
	logic [cpu_pkg::line_off_w-1:0] beat_cnt;
	logic                           fill_pulse;
	logic [cpu_pkg::word_w-1:0]     word_q;
	logic                           hit;
	logic                           beat_match;

	// tag is the top of the word index
	assign hit = line_valid
		&& (line_tag == pc_index[cpu_pkg::addr_w-1 -: cpu_pkg::tag_w]);

	assign beat_match = (beat_cnt == req_index[cpu_pkg::line_off_w-1:0]);

	// ----------------------------------------------------------------------
	// state machine
	// ----------------------------------------------------------------------
	always_comb begin
		state_nx = state;
		case (state)
			cpu_pkg::cs_idle: begin
				if (fetch) begin
					if (hit)
						state_nx = cpu_pkg::cs_hit;
					else
						state_nx = cpu_pkg::cs_fill;
				end
			end
			cpu_pkg::cs_hit:
				state_nx = cpu_pkg::cs_deliver;
			cpu_pkg::cs_fill: begin
				if (fill_rsp.valid && fill_rsp.last)
					state_nx = cpu_pkg::cs_deliver;
			end
			cpu_pkg::cs_deliver:
				state_nx = cpu_pkg::cs_idle;
			default:
				state_nx = cpu_pkg::cs_idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= cpu_pkg::cs_idle;
		else
			state <= state_nx;
	end

	// ----------------------------------------------------------------------
	// line bookkeeping
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			line_valid <= 1'b0;
			line_tag   <= '0;
			req_index  <= '0;
			beat_cnt   <= '0;
			fill_pulse <= 1'b0;
		end else begin
			fill_pulse <= (state == cpu_pkg::cs_idle) && fetch && !hit;
			if (fetch)
				req_index <= pc_index;
			// line is torn while the burst overwrites it
			if ((state == cpu_pkg::cs_idle) && fetch && !hit)
				line_valid <= 1'b0;
			// counter wraps back to 0 after the last beat
			if (fill_rsp.valid) begin
				beat_cnt <= beat_cnt + 1'b1;
				if (fill_rsp.last) begin
					line_valid <= 1'b1;
					line_tag   <= req_index[cpu_pkg::addr_w-1 -: cpu_pkg::tag_w];
				end
			end
		end
	end

	// beats go into the array, the wanted one is also kept aside
	always_ff @(posedge clk) begin
		if (fill_rsp.valid)
			line_mem[beat_cnt] <= fill_rsp.data;
		if (state == cpu_pkg::cs_hit)
			word_q <= line_mem[req_index[cpu_pkg::line_off_w-1:0]];
		else if ((state == cpu_pkg::cs_fill) && fill_rsp.valid && beat_match)
			word_q <= fill_rsp.data;
	end

	assign inst_valid = (state == cpu_pkg::cs_deliver);
	assign inst       = cpu_pkg::instr_t'(word_q);
	assign fill_req   = '{
		valid: fill_pulse,
		tag:   req_index[cpu_pkg::addr_w-1 -: cpu_pkg::tag_w]
	};

	a_beat_in_fill: assert property (@(posedge clk) disable iff (!rst_n)
		fill_rsp.valid |-> (state == cpu_pkg::cs_fill));

	a_fetch_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
		fetch |-> (state == cpu_pkg::cs_idle));

endmodule

//--- source/reg_file.sv
// sixteen signed registers, two combinational reads, one clocked write
`timescale 1ns/1ps

module reg_file (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [cpu_pkg::reg_num_w-1:0] rs_num,
	input  logic [cpu_pkg::reg_num_w-1:0] rt_num,
	output logic [cpu_pkg::word_w-1:0]    rs_val,
	output logic [cpu_pkg::word_w-1:0]    rt_val,
	input  cpu_pkg::reg_write_t           wr
);

	logic signed [cpu_pkg::word_w-1:0] regs [cpu_pkg::reg_count];

	// ----------------------------------------------------------------------
	// write port
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < cpu_pkg::reg_count; i++)
				regs[i] <= '0;
		end else if (wr.en) begin
			regs[wr.num] <= wr.data;
		end
	end

	// ----------------------------------------------------------------------
	// read ports
	// ----------------------------------------------------------------------
	// no bypass, the sequencer never reads in the write cycle
	assign rs_val = regs[rs_num];
	assign rt_val = regs[rt_num];

endmodule
